// ==== filelist.f ====
rtl/cb_pkg.sv
rtl/cb_sweep_ctrl.sv
rtl/cb_bank_array.sv
rtl/cb_douta_map.sv
rtl/pe_operand_stage.sv
rtl/cb_read_top.sv
testbench/cb_read_props.sv
testbench/tb_cb_read.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cb_read -f filelist.f \
  && ./obj_dir/Vtb_cb_read | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "simulation result: PASS" \
  || { echo "simulation result: FAIL"; exit 1; }

// ==== testbench/tb_cb_read.sv ====
`timescale 1ns/1ps

module tb_cb_read;
  import cb_pkg::*;

  localparam int RSA_DW     = 16;
  localparam int ROW_LEN    = 10;
  localparam int VW         = CB_LANES * RSA_DW;
  localparam int NROWS      = 2 ** ROW_LEN;
  localparam int PERIOD_NS  = 100;
  localparam int FILL_ROWS  = 32;                  // Sweeps stay inside the filled window.
  localparam int N_REWRITE  = 8;
  localparam int N_SWEEPS   = 16;
  localparam int MAX_LEN    = 8;
  localparam int CYC_MARGIN = 4;
  localparam int PLAN_XFERS = 2 * FILL_ROWS * CB_LANES + N_REWRITE * (1 + CB_LANES)
                              + N_SWEEPS * (4 + MAX_LEN) + 6;
  localparam int PLAN_ROWS  = N_SWEEPS * MAX_LEN;
  localparam int TIMEOUT_NS = (PLAN_XFERS + PLAN_ROWS) * CYC_MARGIN * PERIOD_NS;

  logic              clk;
  logic              sys_rst;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [WB_AW-1:0]  wb_adr;
  logic [RSA_DW-1:0] wb_wdat;
  logic [RSA_DW-1:0] wb_rdat;
  logic              wb_ack;
  logic [VW-1:0]     a_opnd;
  logic [VW-1:0]     b_opnd;
  logic [VW-1:0]     m_opnd;
  logic              opnd_valid;
  logic [1:0]        opnd_target;
  logic              opnd_last;

  logic [15:0]       lfsr;
  logic [RSA_DW-1:0] shadow [NROWS*CB_LANES];      // Bank model, indexed by row and lane.
  logic [VW-1:0]     exp_a [$];
  logic [VW-1:0]     exp_b [$];
  logic [VW-1:0]     exp_m [$];
  logic [1:0]        exp_tgt [$];
  logic              exp_last [$];
  int                errors;
  int                rows_seen;
  int                base_row;

  cb_read_top #(
    .RSA_DW  (RSA_DW),
    .ROW_LEN (ROW_LEN)
  ) i_cb_read_top (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_wb_cyc      (wb_cyc),
    .i_wb_stb      (wb_stb),
    .i_wb_we       (wb_we),
    .i_wb_adr      (wb_adr),
    .i_wb_dat      (wb_wdat),
    .o_wb_dat      (wb_rdat),
    .o_wb_ack      (wb_ack),
    .o_a_opnd      (a_opnd),
    .o_b_opnd      (b_opnd),
    .o_m_opnd      (m_opnd),
    .o_opnd_valid  (opnd_valid),
    .o_opnd_target (opnd_target),
    .o_opnd_last   (opnd_last)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // ----------------------------------------
  // Random source and reference model
  // ----------------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16, 14, 13 and 11.
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = (r << 1) | int'(lfsr[0]);
    end
    return r;
  endfunction

  // Banks feeding {lane 1, lane 0} in new-landmark mode.
  function automatic logic [3:0] landmark_banks(input logic [1:0] lo);
    case (lo)
      2'b11:   return {2'd1, 2'd0};
      2'b00:   return {2'd3, 2'd2};
      2'b01:   return {2'd2, 2'd3};
      default: return {2'd0, 2'd1};
    endcase
  endfunction

  function automatic logic [VW-1:0] model_row(input int row, input logic [1:0] mode,
                                              input logic [1:0] lmk_lo);
    logic [VW-1:0] v;
    logic [3:0]    pair;
    int            bank;
    v    = '0;
    pair = landmark_banks(lmk_lo);
    for (int lane = 0; lane < CB_LANES; lane++) begin
      case (mode)
        MODE_POS: bank = lane;
        MODE_NEG: bank = CB_LANES - 1 - lane;
        MODE_NEW: bank = (lane == 0) ? int'(pair[1:0]) : (lane == 1) ? int'(pair[3:2]) : -1;
        default:  bank = -1;                        // Idle leaves the lane zero.
      endcase
      if (bank >= 0)
        v[lane*RSA_DW +: RSA_DW] = shadow[row * CB_LANES + bank];
    end
    return v;
  endfunction

  function automatic logic [WB_AW-1:0] mem_adr(input int row, input int lane);
    return WB_AW'((1 << MEM_SPACE_BIT) | ((row % NROWS) << 2) | lane);
  endfunction

  function automatic logic [WB_AW-1:0] reg_adr(input logic [REG_AW-1:0] off);
    return WB_AW'(off);
  endfunction

  task automatic check_value(input logic [VW-1:0] got, input logic [VW-1:0] exp,
                             input string what);
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // Wishbone master
  // ----------------------------------------
  task automatic wait_ack();
    @(negedge clk);
    while (!wb_ack)
      @(negedge clk);
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [RSA_DW-1:0] dat);
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = 1'b1;
    wb_adr  = adr;
    wb_wdat = dat;
    wait_ack();
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;                                  // Released only after the ack edge.
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [RSA_DW-1:0] dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack();
    dat = wb_rdat;
    @(posedge clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // ----------------------------------------
  // Sweeps and operand monitor
  // ----------------------------------------
  task automatic start_sweep(input logic [1:0] tgt, input logic [1:0] mode, input int start,
                             input int len, input int lmk);
    logic [VW-1:0] row;
    for (int i = 0; i < len; i++) begin
      row = model_row((start + i) % NROWS, mode, lmk[1:0]);
      exp_a.push_back(tgt == TGT_A ? row : '0);
      exp_b.push_back(tgt == TGT_B ? row : '0);
      exp_m.push_back(tgt == TGT_M ? row : '0);
      exp_tgt.push_back(tgt);
      exp_last.push_back(i == len - 1);
    end
    wb_write(reg_adr(REG_ROW), RSA_DW'(start));
    wb_write(reg_adr(REG_LEN), RSA_DW'(len));
    wb_write(reg_adr(REG_LMK), RSA_DW'(lmk));
    wb_write(reg_adr(REG_GO), RSA_DW'({tgt, mode}));
  endtask

  task automatic finish_sweep();
    logic [RSA_DW-1:0] status;
    wb_read(reg_adr(REG_STATUS), status);
    check_value(VW'(status), VW'(1), "status during sweep");
    while (status[0])
      wb_read(reg_adr(REG_STATUS), status);
    assert (exp_a.size() == 0) else begin
      errors++;
      $display("Sweep ended at %0t with %0d expected rows never presented", $time, exp_a.size());
    end
  endtask

  task automatic random_sweep(input logic [1:0] tgt, input logic [1:0] mode, input int lmk);
    int start;
    int len;
    start = (base_row + rand_bits(4)) % NROWS;
    len   = 1 + rand_bits(3);
    start_sweep(tgt, mode, start, len, lmk);
    finish_sweep();
  endtask

  task automatic check_row();
    assert (exp_a.size() > 0) else begin
      errors++;
      $display("Operand row at %0t arrived when no row was expected", $time);
    end
    if (exp_a.size() > 0) begin
      check_value(a_opnd, exp_a.pop_front(), "operand A");
      check_value(b_opnd, exp_b.pop_front(), "operand B");
      check_value(m_opnd, exp_m.pop_front(), "operand M");
      check_value(VW'(opnd_target), VW'(exp_tgt.pop_front()), "target tag");
      check_value(VW'(opnd_last), VW'(exp_last.pop_front()), "last flag");
      rows_seen++;
    end
  endtask

  always @(negedge clk) begin
    if (!sys_rst) begin
      if (opnd_valid)
        check_row();
      else
        check_value(a_opnd | b_opnd | m_opnd | VW'({opnd_last, opnd_target}), '0,
                    "operand outputs between rows");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("tests failed");
    $finish;
  end

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int                r;
    int                lane;
    int                start;
    int                len;
    int                prop_fails;
    logic [RSA_DW-1:0] val;
    logic [RSA_DW-1:0] rd;
    errors    = 0;
    rows_seen = 0;
    lfsr      = 16'd2;
    sys_rst   = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_wdat   = '0;
    repeat (3) @(posedge clk);
    #1;
    sys_rst = 1'b0;
    check_value(VW'({wb_ack, opnd_valid, opnd_last}), '0, "control outputs after reset");
    check_value(a_opnd | b_opnd | m_opnd, '0, "operand buses after reset");
    wb_read(reg_adr(REG_STATUS), rd);
    check_value(VW'(rd), '0, "status after reset");

    base_row = rand_bits(ROW_LEN);
    for (int k = 0; k < FILL_ROWS * CB_LANES; k++) begin
      val = RSA_DW'(rand_bits(RSA_DW));
      shadow[((base_row + k / CB_LANES) % NROWS) * CB_LANES + k % CB_LANES] = val;
      wb_write(mem_adr(base_row + k / CB_LANES, k % CB_LANES), val);
    end
    for (int k = 0; k < FILL_ROWS * CB_LANES; k++) begin
      wb_read(mem_adr(base_row + k / CB_LANES, k % CB_LANES), rd);
      check_value(VW'(rd), VW'(shadow[((base_row + k / CB_LANES) % NROWS) * CB_LANES
                                      + k % CB_LANES]), "bank readback");
    end
    for (int k = 0; k < N_REWRITE; k++) begin
      r    = (base_row + rand_bits(5)) % NROWS;
      lane = rand_bits(2);
      val  = RSA_DW'(rand_bits(RSA_DW));
      shadow[r * CB_LANES + lane] = val;
      wb_write(mem_adr(r, lane), val);
      for (int l = 0; l < CB_LANES; l++) begin
        wb_read(mem_adr(r, l), rd);
        check_value(VW'(rd), VW'(shadow[r * CB_LANES + l]), "lane after rewrite");
      end
    end

    for (int t = 1; t < 4; t++) begin
      random_sweep(2'(t), MODE_POS, 0);
      random_sweep(2'(t), MODE_POS, 0);
    end
    for (int t = 1; t < 4; t++)
      random_sweep(2'(t), MODE_NEG, 0);
    for (int lo = 0; lo < 4; lo++)
      random_sweep(2'(1 + lo % 3), MODE_NEW, (rand_bits(ROW_LEN - 2) << 2) | lo);
    random_sweep(TGT_M, MODE_IDLE, 0);

    // A GO without a target leaves the engine idle and presents no rows.
    wb_write(reg_adr(REG_GO), RSA_DW'({TGT_NONE, MODE_POS}));
    wb_read(reg_adr(REG_STATUS), rd);
    check_value(VW'(rd), '0, "status after GO without target");

    // A bank write during the sweep is held until the pipeline drains.
    start = (base_row + rand_bits(4)) % NROWS;
    len   = 4 + rand_bits(2);
    r     = (start + len - 1) % NROWS;
    lane  = rand_bits(2);
    val   = RSA_DW'(rand_bits(RSA_DW));
    start_sweep(TGT_B, MODE_POS, start, len, 0);
    wb_write(mem_adr(r, lane), val);
    assert (exp_a.size() == 0) else begin
      errors++;
      $display("Bank write during a sweep was acked at %0t before the last row", $time);
    end
    shadow[r * CB_LANES + lane] = val;
    wb_read(reg_adr(REG_STATUS), rd);
    check_value(VW'(rd), '0, "status after held write");
    start_sweep(TGT_M, MODE_POS, start, len, 0);
    finish_sweep();

    prop_fails = i_cb_read_top.i_cb_sweep_ctrl.i_cb_read_props.fail_cnt;
    $display("Summary: %0d check errors, %0d property failures, %0d rows checked",
             errors, prop_fails, rows_seen);
    if (errors + prop_fails == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// ==== testbench/cb_read_props.sv ====
`timescale 1ns/1ps

module cb_read_props (
  input logic       clk,
  input logic       sys_rst,
  input logic       i_wb_cyc,
  input logic       i_wb_stb,
  input logic       i_wb_ack,
  input logic       i_busy,
  input logic       i_row_valid,
  input logic [3:0] i_map_sel
);
  import cb_pkg::*;

  int fail_cnt = 0;                                 // Read by the testbench summary.

  // ----------------------------------------
  // Wishbone handshake
  // ----------------------------------------
  ack_in_request: assert property (@(posedge clk) disable iff (sys_rst)
    i_wb_ack |-> (i_wb_cyc && i_wb_stb))
    else begin
      $error("Ack seen without an active Wishbone request.");
      fail_cnt++;
    end

  single_ack: assert property (@(posedge clk) disable iff (sys_rst)
    (i_wb_cyc && i_wb_stb && i_wb_ack) |=> !i_wb_ack)
    else begin
      $error("Ack held high on two cycles of one request.");
      fail_cnt++;
    end

  // ----------------------------------------
  // Sweep pipeline
  // ----------------------------------------
  valid_only_busy: assert property (@(posedge clk) disable iff (sys_rst)
    i_row_valid |-> i_busy)
    else begin
      $error("Row valid while the sweep engine is idle.");
      fail_cnt++;
    end

  target_set: assert property (@(posedge clk) disable iff (sys_rst)
    i_row_valid |-> (i_map_sel[3:2] != TGT_NONE))
    else begin
      $error("Valid row carries no operand target.");
      fail_cnt++;
    end

endmodule

bind cb_sweep_ctrl cb_read_props i_cb_read_props (
  .clk         (clk),
  .sys_rst     (sys_rst),
  .i_wb_cyc    (i_wb_cyc),
  .i_wb_stb    (i_wb_stb),
  .i_wb_ack    (o_wb_ack),
  .i_busy      (busy),
  .i_row_valid (o_row_valid),
  .i_map_sel   (o_map_sel)
);

// ==== rtl/cb_read_top.sv ====
`timescale 1ns/1ps

module cb_read_top #(
  parameter int RSA_DW  = 16,
  parameter int ROW_LEN = 10
) (
  input  logic                               clk,
  input  logic                               sys_rst,
  input  logic                               i_wb_cyc,
  input  logic                               i_wb_stb,
  input  logic                               i_wb_we,
  input  logic [cb_pkg::WB_AW-1:0]           i_wb_adr,
  input  logic [RSA_DW-1:0]                  i_wb_dat,
  output logic [RSA_DW-1:0]                  o_wb_dat,
  output logic                               o_wb_ack,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_a_opnd,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_b_opnd,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_m_opnd,
  output logic                               o_opnd_valid,
  output logic [1:0]                         o_opnd_target,
  output logic                               o_opnd_last
);
  import cb_pkg::*;

  logic [ROW_LEN-1:0]         bank_addr;
  logic                       bank_we;
  logic [CB_LANE_W-1:0]       bank_wlane;
  logic [RSA_DW-1:0]          bank_wdata;
  logic [CB_LANES*RSA_DW-1:0] bank_rdata;
  logic [3:0]                 map_sel;
  logic [ROW_LEN-1:0]         landmark_num;
  logic                       row_valid;
  logic                       row_last;
  logic [CB_LANES*RSA_DW-1:0] a_vec;
  logic [CB_LANES*RSA_DW-1:0] b_vec;
  logic [CB_LANES*RSA_DW-1:0] m_vec;

  // ----------------------------------------
  // Producer, buffer and consumer
  // ----------------------------------------
  cb_sweep_ctrl #(
    .RSA_DW  (RSA_DW),
    .ROW_LEN (ROW_LEN)
  ) i_cb_sweep_ctrl (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .i_bank_rdata   (bank_rdata),
    .o_bank_addr    (bank_addr),
    .o_bank_we      (bank_we),
    .o_bank_wlane   (bank_wlane),
    .o_bank_wdata   (bank_wdata),
    .o_map_sel      (map_sel),
    .o_landmark_num (landmark_num),
    .o_row_valid    (row_valid),
    .o_row_last     (row_last)
  );

  cb_bank_array #(
    .RSA_DW  (RSA_DW),
    .ROW_LEN (ROW_LEN)
  ) i_cb_bank_array (
    .clk     (clk),
    .i_addr  (bank_addr),
    .i_we    (bank_we),
    .i_wlane (bank_wlane),
    .i_wdata (bank_wdata),
    .o_rdata (bank_rdata)
  );

  cb_douta_map #(
    .RSA_DW  (RSA_DW),
    .ROW_LEN (ROW_LEN)
  ) i_cb_douta_map (
    .clk            (clk),
    .sys_rst        (sys_rst),
    .i_cb_douta_sel (map_sel),
    .i_landmark_num (landmark_num),
    .i_cb_douta     (bank_rdata),
    .o_a_cb_douta   (a_vec),
    .o_b_cb_douta   (b_vec),
    .o_m_cb_douta   (m_vec)
  );

  pe_operand_stage #(
    .RSA_DW (RSA_DW)
  ) i_pe_operand_stage (
    .clk           (clk),
    .sys_rst       (sys_rst),
    .i_a_vec       (a_vec),
    .i_b_vec       (b_vec),
    .i_m_vec       (m_vec),
    .i_row_valid   (row_valid),
    .i_row_last    (row_last),
    .i_target      (map_sel[3:2]),
    .o_a_opnd      (o_a_opnd),
    .o_b_opnd      (o_b_opnd),
    .o_m_opnd      (o_m_opnd),
    .o_opnd_valid  (o_opnd_valid),
    .o_opnd_target (o_opnd_target),
    .o_opnd_last   (o_opnd_last)
  );

endmodule

// ==== rtl/pe_operand_stage.sv ====
`timescale 1ns/1ps

module pe_operand_stage #(
  parameter int RSA_DW = 16
) (
  input  logic                               clk,
  input  logic                               sys_rst,
  input  logic [cb_pkg::CB_LANES*RSA_DW-1:0] i_a_vec,
  input  logic [cb_pkg::CB_LANES*RSA_DW-1:0] i_b_vec,
  input  logic [cb_pkg::CB_LANES*RSA_DW-1:0] i_m_vec,
  input  logic                               i_row_valid,
  input  logic                               i_row_last,
  input  logic [1:0]                         i_target,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_a_opnd,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_b_opnd,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_m_opnd,
  output logic                               o_opnd_valid,
  output logic [1:0]                         o_opnd_target,
  output logic                               o_opnd_last
);
  import cb_pkg::*;

  // ----------------------------------------
  // Operand register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a_opnd      <= '0;
      o_b_opnd      <= '0;
      o_m_opnd      <= '0;
      o_opnd_valid  <= 1'b0;
      o_opnd_target <= TGT_NONE;
      o_opnd_last   <= 1'b0;
    end else if (i_row_valid) begin
      o_a_opnd      <= i_a_vec;
      o_b_opnd      <= i_b_vec;
      o_m_opnd      <= i_m_vec;
      o_opnd_valid  <= 1'b1;
      o_opnd_target <= i_target;                     // Select is stable for the whole sweep.
      o_opnd_last   <= i_row_last;
    end else begin
      // Host reads also move the bank data, so gaps must not leak it to the array.
      o_a_opnd      <= '0;
      o_b_opnd      <= '0;
      o_m_opnd      <= '0;
      o_opnd_valid  <= 1'b0;
      o_opnd_target <= TGT_NONE;
      o_opnd_last   <= 1'b0;
    end
  end

endmodule

// ==== rtl/cb_douta_map.sv ====
`timescale 1ns/1ps

module cb_douta_map #(
  parameter int RSA_DW  = 16,
  parameter int ROW_LEN = 10
) (
  input  logic                               clk,
  input  logic                               sys_rst,
  input  logic [3:0]                         i_cb_douta_sel,
  input  logic [ROW_LEN-1:0]                 i_landmark_num,
  input  logic [cb_pkg::CB_LANES*RSA_DW-1:0] i_cb_douta,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_a_cb_douta,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_b_cb_douta,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_m_cb_douta
);
  import cb_pkg::*;

  localparam int VW = CB_LANES * RSA_DW;

  cb_target_e        target;
  cb_mode_e          mode;
  logic [RSA_DW-1:0] lane_in  [CB_LANES];
  logic [RSA_DW-1:0] lane_out [CB_LANES];
  logic [VW-1:0]     mapped;

  assign target = cb_target_e'(i_cb_douta_sel[3:2]);
  assign mode   = cb_mode_e'(i_cb_douta_sel[1:0]);

  // ----------------------------------------
  // Lane reordering
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < CB_LANES; i++) begin
      lane_in[i]  = i_cb_douta[i*RSA_DW +: RSA_DW];
      lane_out[i] = '0;                                // Idle mode leaves every lane zero.
    end
    case (mode)
      MODE_POS: begin
        for (int i = 0; i < CB_LANES; i++)
          lane_out[i] = lane_in[i];
      end
      MODE_NEG: begin
        for (int i = 0; i < CB_LANES; i++)
          lane_out[i] = lane_in[CB_LANES-1-i];
      end
      MODE_NEW: begin
        // The landmark's low bits pick the bank pair, upper lanes stay zero.
        case (i_landmark_num[1:0])
          2'b11: begin
            lane_out[0] = lane_in[0];
            lane_out[1] = lane_in[1];
          end
          2'b00: begin
            lane_out[0] = lane_in[2];
            lane_out[1] = lane_in[3];
          end
          2'b01: begin
            lane_out[0] = lane_in[3];
            lane_out[1] = lane_in[2];
          end
          default: begin
            lane_out[0] = lane_in[1];
            lane_out[1] = lane_in[0];
          end
        endcase
      end
      default: ;
    endcase
    for (int i = 0; i < CB_LANES; i++)
      mapped[i*RSA_DW +: RSA_DW] = lane_out[i];
  end

  // ----------------------------------------
  // Per-target output registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_a_cb_douta <= '0;
      o_b_cb_douta <= '0;
      o_m_cb_douta <= '0;
    end else begin
      o_a_cb_douta <= (target == TGT_A) ? mapped : '0; // Only the addressed target loads.
      o_b_cb_douta <= (target == TGT_B) ? mapped : '0;
      o_m_cb_douta <= (target == TGT_M) ? mapped : '0;
    end
  end

endmodule

// ==== rtl/cb_bank_array.sv ====
`timescale 1ns/1ps

module cb_bank_array #(
  parameter int RSA_DW  = 16,
  parameter int ROW_LEN = 10
) (
  input  logic                               clk,
  input  logic [ROW_LEN-1:0]                 i_addr,
  input  logic                               i_we,
  input  logic [cb_pkg::CB_LANE_W-1:0]       i_wlane,
  input  logic [RSA_DW-1:0]                  i_wdata,
  output logic [cb_pkg::CB_LANES*RSA_DW-1:0] o_rdata
);
  import cb_pkg::*;

  localparam int DEPTH = 2 ** ROW_LEN;

  // ----------------------------------------
  // One single-port bank per lane
  // ----------------------------------------
  for (genvar g = 0; g < CB_LANES; g++) begin : g_bank
    logic [RSA_DW-1:0] mem [DEPTH];
    logic              lane_we;

    assign lane_we = i_we && (i_wlane == CB_LANE_W'(g)); // Host writes one lane at a time.

    always_ff @(posedge clk) begin
      if (lane_we)
        mem[i_addr] <= i_wdata;
      o_rdata[g*RSA_DW +: RSA_DW] <= mem[i_addr];    // Read returns the old word on a write.
    end
  end

endmodule

// ==== rtl/cb_sweep_ctrl.sv ====
`timescale 1ns/1ps

module cb_sweep_ctrl #(
  parameter int RSA_DW  = 16,
  parameter int ROW_LEN = 10
) (
  input  logic                               clk,
  input  logic                               sys_rst,
  input  logic                               i_wb_cyc,
  input  logic                               i_wb_stb,
  input  logic                               i_wb_we,
  input  logic [cb_pkg::WB_AW-1:0]           i_wb_adr,
  input  logic [RSA_DW-1:0]                  i_wb_dat,
  output logic [RSA_DW-1:0]                  o_wb_dat,
  output logic                               o_wb_ack,
  input  logic [cb_pkg::CB_LANES*RSA_DW-1:0] i_bank_rdata,
  output logic [ROW_LEN-1:0]                 o_bank_addr,
  output logic                               o_bank_we,
  output logic [cb_pkg::CB_LANE_W-1:0]       o_bank_wlane,
  output logic [RSA_DW-1:0]                  o_bank_wdata,
  output logic [3:0]                         o_map_sel,
  output logic [ROW_LEN-1:0]                 o_landmark_num,
  output logic                               o_row_valid,
  output logic                               o_row_last
);
  import cb_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_SWEEP, ST_DRAIN} state_e;

  state_e              state_q;
  logic [ROW_LEN-1:0]  start_q;
  logic [ROW_LEN-1:0]  len_q;
  logic [ROW_LEN-1:0]  lmk_q;
  logic [3:0]          sel_q;
  logic [ROW_LEN-1:0]  row_ptr_q;
  logic [ROW_LEN-1:0]  cnt_q;
  logic [ROW_LEN-1:0]  lmk_act_q;
  logic                rd_pend_q;
  logic [1:0]          row_v_q;
  logic [1:0]          row_l_q;
  logic [REG_AW-1:0]   reg_off;
  logic [RSA_DW-1:0]   reg_rdata;
  logic                busy;
  logic                req;
  logic                is_mem;
  logic                acc;
  logic                mem_rd;
  logic                reg_wr;
  logic                go_start;
  logic                issue;

  // ----------------------------------------
  // Host decode
  // ----------------------------------------
  assign busy    = (state_q != ST_IDLE);
  assign is_mem  = i_wb_adr[MEM_SPACE_BIT];
  assign reg_off = i_wb_adr[REG_AW-1:0];
  assign req     = i_wb_cyc && i_wb_stb && !o_wb_ack && !rd_pend_q; // One transfer in flight.
  // Bank traffic and a new GO wait until the pipeline has drained.
  assign acc      = req && !(busy && (is_mem || (i_wb_we && reg_off == REG_GO)));
  assign mem_rd   = acc && is_mem && !i_wb_we;
  assign reg_wr   = acc && !is_mem && i_wb_we;
  assign go_start = reg_wr && (reg_off == REG_GO) && (i_wb_dat[3:2] != TGT_NONE);
  assign issue    = (state_q == ST_SWEEP);

  assign o_bank_addr  = issue ? row_ptr_q : i_wb_adr[ROW_LEN+1:2];
  assign o_bank_we    = acc && is_mem && i_wb_we;
  assign o_bank_wlane = i_wb_adr[CB_LANE_W-1:0];
  assign o_bank_wdata = i_wb_dat;

  always_comb begin
    case (reg_off)
      REG_ROW:    reg_rdata = RSA_DW'(start_q);
      REG_LEN:    reg_rdata = RSA_DW'(len_q);
      REG_LMK:    reg_rdata = RSA_DW'(lmk_q);
      REG_GO:     reg_rdata = RSA_DW'(sel_q);
      REG_STATUS: reg_rdata = RSA_DW'(busy);
      default:    reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      o_wb_ack  <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_rd;
      o_wb_ack  <= (acc && !mem_rd) || rd_pend_q; // Bank reads wait for the registered row.
    end
  end

  always_ff @(posedge clk) begin
    if (rd_pend_q)
      o_wb_dat <= i_bank_rdata[i_wb_adr[CB_LANE_W-1:0]*RSA_DW +: RSA_DW];
    else if (acc && !is_mem && !i_wb_we)
      o_wb_dat <= reg_rdata;
  end

  // ----------------------------------------
  // Command registers and sweep FSM
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state_q   <= ST_IDLE;
      start_q   <= '0;
      len_q     <= '0;
      lmk_q     <= '0;
      sel_q     <= '0;
      row_ptr_q <= '0;
      cnt_q     <= '0;
      lmk_act_q <= '0;
    end else begin
      if (reg_wr) begin
        case (reg_off)
          REG_ROW: start_q <= i_wb_dat[ROW_LEN-1:0];
          REG_LEN: len_q   <= i_wb_dat[ROW_LEN-1:0];
          REG_LMK: lmk_q   <= i_wb_dat[ROW_LEN-1:0];
          REG_GO:  sel_q   <= i_wb_dat[3:0];
          default: ;
        endcase
      end
      case (state_q)
        ST_IDLE: begin
          if (go_start) begin
            row_ptr_q <= start_q;
            lmk_act_q <= lmk_q;                        // Held for the whole sweep.
            if (len_q == '0) begin
              state_q <= ST_DRAIN;
              cnt_q   <= ROW_LEN'(2);
            end else begin
              state_q <= ST_SWEEP;
              cnt_q   <= len_q;
            end
          end
        end
        ST_SWEEP: begin
          row_ptr_q <= row_ptr_q + 1'b1;
          cnt_q     <= cnt_q - 1'b1;
          if (cnt_q == ROW_LEN'(1)) begin
            state_q <= ST_DRAIN;
            cnt_q   <= ROW_LEN'(2);                    // Two stages still hold rows.
          end
        end
        ST_DRAIN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == ROW_LEN'(1))
            state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Select and landmark line up with the bank data, row flags with the map output.
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      row_v_q        <= '0;
      row_l_q        <= '0;
      o_map_sel      <= '0;
      o_landmark_num <= '0;
    end else begin
      row_v_q        <= {row_v_q[0], issue};
      row_l_q        <= {row_l_q[0], issue && (cnt_q == ROW_LEN'(1))};
      o_map_sel      <= sel_q;
      o_landmark_num <= lmk_act_q;
    end
  end

  assign o_row_valid = row_v_q[1];
  assign o_row_last  = row_l_q[1];

endmodule

// ==== rtl/cb_pkg.sv ====
package cb_pkg;

  // ----------------------------------------
  // Bank geometry and host address layout
  // ----------------------------------------
  localparam int CB_LANES      = 4;                  // New-landmark mapping needs four banks.
  localparam int CB_LANE_W     = $clog2(CB_LANES);
  localparam int WB_AW         = 16;
  localparam int MEM_SPACE_BIT = 15;                 // Set for bank memory, clear for registers.
  localparam int REG_AW        = 3;

  // ----------------------------------------
  // Select codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    TGT_NONE = 2'b00,
    TGT_A    = 2'b01,
    TGT_B    = 2'b10,
    TGT_M    = 2'b11
  } cb_target_e;

  typedef enum logic [1:0] {
    MODE_IDLE = 2'b00,
    MODE_POS  = 2'b01,
    MODE_NEG  = 2'b10,
    MODE_NEW  = 2'b11                                // Lanes 2 and 3 are zeroed.
  } cb_mode_e;

  // ----------------------------------------
  // Register window
  // ----------------------------------------
  localparam logic [REG_AW-1:0] REG_ROW    = 3'd0;
  localparam logic [REG_AW-1:0] REG_LEN    = 3'd1;
  localparam logic [REG_AW-1:0] REG_LMK    = 3'd2;
  localparam logic [REG_AW-1:0] REG_GO     = 3'd3;  // Data bits 3:2 target, 1:0 mode.
  localparam logic [REG_AW-1:0] REG_STATUS = 3'd4;  // Bit 0 is busy.

endpackage
